// File: rmsPkg.sv
/*
  Widths, Wishbone register map and signal bundles of the RMS magnitude path.
  The RTL and the testbench take these by a wildcard import.
*/
package rmsPkg;

    localparam int NumAdc       = 4;
    localparam int AdcWidth     = 16;
    localparam int MagWidth     = 26;
    localparam int GainWidth    = 18;
    localparam int GainFracBits = 16;
    localparam int SquareWidth  = 31;
    localparam int ShiftWidth   = 4;
    localparam int WbDataWidth  = 32;
    localparam int WbAddrWidth  = 3;

    // Register map
    localparam logic [WbAddrWidth-1:0] AddrCsr   = 3'd0;
    localparam logic [WbAddrWidth-1:0] AddrGain0 = 3'd1;
    localparam logic [WbAddrWidth-1:0] AddrGain1 = 3'd2;
    localparam logic [WbAddrWidth-1:0] AddrGain2 = 3'd3;
    localparam logic [WbAddrWidth-1:0] AddrGain3 = 3'd4;

    // CSR fields
    localparam int CsrOverflowBit = 0;
    localparam int CsrShiftLsb    = 4;

    // 1.0 in unsigned 2.16 format
    localparam logic [GainWidth-1:0] GainUnity = 1 << GainFracBits;

    typedef struct packed {
        logic [NumAdc-1:0][AdcWidth-1:0] ch;
    } adcSamples_t;

    typedef struct packed {
        logic [NumAdc-1:0][SquareWidth-1:0] ch;
    } squares_t;

    typedef struct packed {
        logic [NumAdc-1:0][MagWidth-1:0] ch;
    } turnMags_t;

    typedef struct packed {
        logic [NumAdc-1:0][GainWidth-1:0] ch;
    } gains_t;

    typedef struct packed {
        logic                   cyc;
        logic                   stb;
        logic                   we;
        logic [WbAddrWidth-1:0] adr;
        logic [WbDataWidth-1:0] dat;
    } wbReq_t;

endpackage

// File: rmsControl.sv
/*
  Wishbone classic register file, turn sample counter and sticky overflow
  status for the RMS path. Drives the shift, the gains and the turnEnd pulse.
*/
`timescale 1ns/1ps

module rmsControl import rmsPkg::*; #(
    parameter int SamplesPerTurn = 77
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  wbReq_t                 wbReq,
    input  logic                   syncMarker,
    input  logic                   overflow,
    output logic                   wbAck,
    output logic [WbDataWidth-1:0] wbDatOut,
    output logic                   turnEnd,
    output logic [ShiftWidth-1:0]  sumShift,
    output gains_t                 gains
);

    localparam int CountWidth = $clog2(SamplesPerTurn + 1);

    logic                   access;
    logic                   ovfSticky;
    logic [WbDataWidth-1:0] readData;
    logic [CountWidth-1:0]  sampleCount;

    ////////////////////////////////////////////////////////////////////////////
    // Wishbone slave

    // New access only while ack is low, so each transfer gets a single ack
    assign access = wbReq.cyc && wbReq.stb && !wbAck;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wbAck     <= 1'b0;
            ovfSticky <= 1'b0;
            sumShift  <= '0;
            for (int i = 0; i < NumAdc; i++) begin
                gains.ch[i] <= GainUnity;
            end
        end else begin
            wbAck <= access;
            // A new overflow wins over a software clear in the same cycle
            if (overflow) begin
                ovfSticky <= 1'b1;
            end else if (access && wbReq.we && wbReq.adr == AddrCsr &&
                         wbReq.dat[CsrOverflowBit]) begin
                ovfSticky <= 1'b0;
            end
            if (access && wbReq.we) begin
                case (wbReq.adr)
                    AddrCsr:   sumShift    <= wbReq.dat[CsrShiftLsb +: ShiftWidth];
                    AddrGain0: gains.ch[0] <= wbReq.dat[GainWidth-1:0];
                    AddrGain1: gains.ch[1] <= wbReq.dat[GainWidth-1:0];
                    AddrGain2: gains.ch[2] <= wbReq.dat[GainWidth-1:0];
                    AddrGain3: gains.ch[3] <= wbReq.dat[GainWidth-1:0];
                    default: ;
                endcase
            end
        end
    end

    always_comb begin
        readData = '0;
        case (wbReq.adr)
            AddrCsr: begin
                readData[CsrOverflowBit]              = ovfSticky;
                readData[CsrShiftLsb +: ShiftWidth]   = sumShift;
            end
            AddrGain0: readData[GainWidth-1:0] = gains.ch[0];
            AddrGain1: readData[GainWidth-1:0] = gains.ch[1];
            AddrGain2: readData[GainWidth-1:0] = gains.ch[2];
            AddrGain3: readData[GainWidth-1:0] = gains.ch[3];
            default: ;
        endcase
    end

    // Read data is captured on the edge that raises ack
    always_ff @(posedge clk) begin
        if (access) begin
            wbDatOut <= readData;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Turn counter over the squares already summed in the current turn

    assign turnEnd = (sampleCount == CountWidth'(SamplesPerTurn - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sampleCount <= '0;
        end else if (syncMarker || turnEnd) begin
            sampleCount <= '0;
        end else begin
            sampleCount <= sampleCount + 1'b1;
        end
    end

    // Classic cycle without wait states
    assert property (@(posedge clk) disable iff (!arstN) wbAck |=> !wbAck);

endmodule

// File: sampleSquarer.sv
/*
  Captures the four ADC samples and the use flag, then registers each
  signed sample squared. Unused samples contribute a zero square.
*/
`timescale 1ns/1ps

module sampleSquarer import rmsPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  adcSamples_t samples,
    input  logic        useSample,
    output squares_t    squares
);

    adcSamples_t sampleReg;
    logic        useReg;
    squares_t    squareNext;

    // Input capture stage
    always_ff @(posedge clk) begin
        sampleReg <= samples;
    end

    always_comb begin
        logic signed [2*AdcWidth-1:0] product;
        product = '0;
        for (int i = 0; i < NumAdc; i++) begin
            product          = $signed(sampleReg.ch[i]) * $signed(sampleReg.ch[i]);
            squareNext.ch[i] = useReg ? product[SquareWidth-1:0] : '0;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            useReg  <= 1'b0;
            squares <= '0;
        end else begin
            useReg  <= useSample;
            squares <= squareNext;
        end
    end

endmodule

// File: turnAccumulator.sv
/*
  Sums each channel's squares over one turn. At turnEnd the sum, current
  square included, is shifted, saturated to MagWidth and published.
*/
`timescale 1ns/1ps

module turnAccumulator import rmsPkg::*; #(
    parameter int SumWidth = 38
) (
    input  logic                  clk,
    input  logic                  arstN,
    input  squares_t              squares,
    input  logic                  turnEnd,
    input  logic [ShiftWidth-1:0] sumShift,
    output turnMags_t             mags,
    output logic                  magValid,
    output logic                  overflow
);

    logic [NumAdc-1:0][SumWidth-1:0] sums;
    logic [NumAdc-1:0][SumWidth-1:0] totals;
    turnMags_t                       magNext;
    logic [NumAdc-1:0]               chanOvf;

    always_comb begin
        logic [SumWidth-1:0] shifted;
        shifted = '0;
        for (int i = 0; i < NumAdc; i++) begin
            totals[i]  = sums[i] + SumWidth'(squares.ch[i]);
            shifted    = totals[i] >> sumShift;
            // Anything above the magnitude range pins to all ones
            chanOvf[i] = |shifted[SumWidth-1:MagWidth];
            magNext.ch[i] = chanOvf[i] ? {MagWidth{1'b1}} : shifted[MagWidth-1:0];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            sums     <= '0;
            magValid <= 1'b0;
            overflow <= 1'b0;
        end else begin
            magValid <= turnEnd;
            overflow <= turnEnd && |chanOvf;
            // Next turn starts from the square after the one at turnEnd
            sums     <= turnEnd ? '0 : totals;
        end
    end

    always_ff @(posedge clk) begin
        if (turnEnd) begin
            mags <= magNext;
        end
    end

    // A turn is always longer than one sample
    assert property (@(posedge clk) disable iff (!arstN) !(turnEnd && magValid));

endmodule

// File: gainTrim.sv
/*
  Applies each channel's 2.16 gain to its turn magnitude and issues the
  turn-by-turn record with a one-cycle valid.
*/
`timescale 1ns/1ps

module gainTrim import rmsPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  turnMags_t mags,
    input  logic      magValid,
    input  gains_t    gains,
    output turnMags_t tbtMags,
    output logic      tbtValid
);

    localparam int ProductWidth = MagWidth + GainWidth;

    turnMags_t trimmed;

    always_comb begin
        logic [ProductWidth-1:0] product;
        logic [ProductWidth-1:0] scaled;
        product = '0;
        scaled  = '0;
        for (int i = 0; i < NumAdc; i++) begin
            product = ProductWidth'(mags.ch[i]) * ProductWidth'(gains.ch[i]);
            scaled  = product >> GainFracBits;
            // Gains above unity can push a product out of range
            trimmed.ch[i] = |scaled[ProductWidth-1:MagWidth] ?
                            {MagWidth{1'b1}} : scaled[MagWidth-1:0];
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            tbtValid <= 1'b0;
        end else begin
            tbtValid <= magValid;
        end
    end

    always_ff @(posedge clk) begin
        if (magValid) begin
            tbtMags <= trimmed;
        end
    end

endmodule

// File: rmsProcessing.sv
/*
  Top of the RMS magnitude path. Connects the register block and the
  squarer, turn accumulator and gain trim datapath on one clock.
*/
`timescale 1ns/1ps

module rmsProcessing import rmsPkg::*; #(
    parameter int SamplesPerTurn = 77,
    parameter int SumWidth       = 38
) (
    input  logic                   clk,
    input  logic                   arstN,
    input  wbReq_t                 wbReq,
    input  logic                   syncMarker,
    input  adcSamples_t            adcSamples,
    input  logic                   useSample,
    output logic                   wbAck,
    output logic [WbDataWidth-1:0] wbDatOut,
    output turnMags_t              tbtMags,
    output logic                   tbtValid
);

    logic                  syncReg;
    logic                  turnEnd;
    logic [ShiftWidth-1:0] sumShift;
    gains_t                gains;
    squares_t              squares;
    turnMags_t             mags;
    logic                  magValid;
    logic                  overflow;

    // Captured on the same edge as the samples, one cycle ahead of the squares
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncReg <= 1'b0;
        end else begin
            syncReg <= syncMarker;
        end
    end

    rmsControl #(
        .SamplesPerTurn(SamplesPerTurn)
    ) i_control (
        .clk       (clk),
        .arstN     (arstN),
        .wbReq     (wbReq),
        .syncMarker(syncReg),
        .overflow  (overflow),
        .wbAck     (wbAck),
        .wbDatOut  (wbDatOut),
        .turnEnd   (turnEnd),
        .sumShift  (sumShift),
        .gains     (gains)
    );

    sampleSquarer i_squarer (
        .clk      (clk),
        .arstN    (arstN),
        .samples  (adcSamples),
        .useSample(useSample),
        .squares  (squares)
    );

    turnAccumulator #(
        .SumWidth(SumWidth)
    ) i_accumulator (
        .clk     (clk),
        .arstN   (arstN),
        .squares (squares),
        .turnEnd (turnEnd),
        .sumShift(sumShift),
        .mags    (mags),
        .magValid(magValid),
        .overflow(overflow)
    );

    gainTrim i_gainTrim (
        .clk     (clk),
        .arstN   (arstN),
        .mags    (mags),
        .magValid(magValid),
        .gains   (gains),
        .tbtMags (tbtMags),
        .tbtValid(tbtValid)
    );

endmodule

// File: rmsChecker.sv
/*
  Watches the TBT outputs and compares the second record after each sync
  with the expected record. Also holds the result counts for the testbench.
*/
`timescale 1ns/1ps

module rmsChecker import rmsPkg::*; (
    input  logic      clk,
    input  logic      arstN,
    input  logic      syncMarker,
    input  logic      tbtValid,
    input  turnMags_t tbtMags,
    input  turnMags_t expMags,
    input  int        testNum,
    output int        recordCount
);

    logic [3:0] syncDelay;
    int         errorCount  = 0;
    int         testsPassed = 0;
    int         testsFailed = 0;
    bit         testFailed  = 1'b0;

    task automatic compareRecord();
        for (int i = 0; i < NumAdc; i++) begin
            if (tbtMags.ch[i] !== expMags.ch[i]) begin
                $display("** Error test %0d ch%0d: expected %0d, actual %0d",
                         testNum, i, expMags.ch[i], tbtMags.ch[i]);
                errorCount++;
                testFailed = 1'b1;
            end
        end
    endtask

    task automatic checkValue(input string label, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (actual !== expected) begin
            $display("** Error %s: expected %0d, actual %0d", label, expected, actual);
            errorCount++;
            testFailed = 1'b1;
        end
    endtask

    task automatic noteFailure(input string what);
        $display("Failure: %s", what);
        errorCount++;
        testFailed = 1'b1;
    endtask

    task automatic finishTest(input string name);
        if (testFailed) begin
            $display("Test %s: failed", name);
            testsFailed++;
        end else begin
            $display("Test %s: passed", name);
            testsPassed++;
        end
        testFailed = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Record counter restarted a few cycles after sync

    // Records still in flight from before the sync are dropped
    always @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            syncDelay   <= '0;
            recordCount <= 0;
        end else begin
            syncDelay <= {syncDelay[2:0], syncMarker};
            if (syncDelay[3]) begin
                recordCount <= 0;
            end else if (tbtValid) begin
                recordCount <= recordCount + 1;
                // First turn may still hold the previous test's samples
                if (recordCount == 1) begin
                    compareRecord();
                end
            end
        end
    end

endmodule

// File: tbRmsProcessing.sv
/*
  Testbench top for the RMS path. Reads tests from rmsPatterns.txt, drives
  Wishbone and ADC stimulus, and lets rmsChecker compare the TBT records.
*/
`timescale 1ns/1ps

module tbRmsProcessing import rmsPkg::*; ();

    localparam int SamplesPerTurn = 77;
    localparam int SumWidth       = 38;
    localparam int MaxTests       = 32;

    logic                   clk;
    logic                   arstN;
    wbReq_t                 wbReq;
    logic                   syncMarker;
    adcSamples_t            adcSamples;
    logic                   useSample;
    logic                   wbAck;
    logic [WbDataWidth-1:0] wbDatOut;
    turnMags_t              tbtMags;
    logic                   tbtValid;
    turnMags_t              expMags;
    int                     testNum;
    int                     recordCount;

    int patNum [MaxTests];
    int patShift [MaxTests];
    int patGain [MaxTests][NumAdc];
    int patAdc [MaxTests][NumAdc];
    int patUse [MaxTests];
    int patExp [MaxTests][NumAdc];
    int numTests;
    int watchdogCycles = 0;

    rmsProcessing #(
        .SamplesPerTurn(SamplesPerTurn),
        .SumWidth      (SumWidth)
    ) i_dut (
        .clk       (clk),
        .arstN     (arstN),
        .wbReq     (wbReq),
        .syncMarker(syncMarker),
        .adcSamples(adcSamples),
        .useSample (useSample),
        .wbAck     (wbAck),
        .wbDatOut  (wbDatOut),
        .tbtMags   (tbtMags),
        .tbtValid  (tbtValid)
    );

    rmsChecker i_checker (
        .clk        (clk),
        .arstN      (arstN),
        .syncMarker (syncMarker),
        .tbtValid   (tbtValid),
        .tbtMags    (tbtMags),
        .expMags    (expMags),
        .testNum    (testNum),
        .recordCount(recordCount)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Limit is (tests + readback) x 3 turns + 50 cycles
    initial begin
        wait (watchdogCycles > 0);
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the run did not finish in %0d cycles", watchdogCycles);
        $display("CHECKS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers

    task automatic loadPatterns();
        int    fd;
        int    count;
        string line;
        fd = $fopen("rmsPatterns.txt", "r");
        numTests = 0;
        if (fd == 0) begin
            i_checker.noteFailure("cannot open rmsPatterns.txt");
            return;
        end
        while (!$feof(fd) && numTests < MaxTests) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line[0] != "#") begin
                count = $sscanf(line, "%d %d %d %d %d %d %d %d %d %d %d %d %d %d %d",
                    patNum[numTests], patShift[numTests],
                    patGain[numTests][0], patGain[numTests][1],
                    patGain[numTests][2], patGain[numTests][3],
                    patAdc[numTests][0], patAdc[numTests][1],
                    patAdc[numTests][2], patAdc[numTests][3],
                    patUse[numTests],
                    patExp[numTests][0], patExp[numTests][1],
                    patExp[numTests][2], patExp[numTests][3]);
                if (count == 15) begin
                    numTests++;
                end
            end
        end
        $fclose(fd);
    endtask

    task automatic wbAccess(input logic we, input logic [WbAddrWidth-1:0] adr,
                            input logic [WbDataWidth-1:0] dat,
                            output logic [WbDataWidth-1:0] rdat);
        int waitCycles;
        waitCycles = 0;
        @(posedge clk);
        #2;
        wbReq.cyc = 1'b1;
        wbReq.stb = 1'b1;
        wbReq.we  = we;
        wbReq.adr = adr;
        wbReq.dat = dat;
        do begin
            @(posedge clk);
            #2;
            waitCycles++;
        end while (!wbAck && waitCycles < 16);
        rdat      = wbDatOut;
        wbReq.cyc = 1'b0;
        wbReq.stb = 1'b0;
        wbReq.we  = 1'b0;
        if (!wbAck) begin
            i_checker.noteFailure("no Wishbone ack within 16 cycles");
        end
    endtask

    task automatic wbWrite(input logic [WbAddrWidth-1:0] adr,
                           input logic [WbDataWidth-1:0] dat);
        logic [WbDataWidth-1:0] unused;
        wbAccess(1'b1, adr, dat, unused);
    endtask

    task automatic wbRead(input logic [WbAddrWidth-1:0] adr,
                          output logic [WbDataWidth-1:0] rdat);
        wbAccess(1'b0, adr, '0, rdat);
    endtask

    task automatic waitRecords(input int count);
        while (recordCount < count) begin
            @(posedge clk);
            #1;
        end
    endtask

    // Overflow follows from the magnitude rule before gain
    function automatic bit expectOverflow(input int idx);
        longint mag;
        bit     ovf;
        ovf = 1'b0;
        for (int i = 0; i < NumAdc; i++) begin
            mag = (longint'(SamplesPerTurn) * patAdc[idx][i] * patAdc[idx][i]) >>
                  patShift[idx];
            if (patUse[idx] != 0 && mag > longint'((1 << MagWidth) - 1)) begin
                ovf = 1'b1;
            end
        end
        return ovf;
    endfunction

    task automatic runTest(input int idx);
        logic [WbDataWidth-1:0] csrWrite;
        logic [WbDataWidth-1:0] rdat;
        bit                     ovf;
        string                  name;
        name     = $sformatf("%0d", patNum[idx]);
        ovf      = expectOverflow(idx);
        csrWrite = (patShift[idx] << CsrShiftLsb) | 1;
        testNum  = patNum[idx];
        for (int i = 0; i < NumAdc; i++) begin
            expMags.ch[i] = MagWidth'(patExp[idx][i]);
        end
        wbWrite(AddrCsr, csrWrite);
        wbWrite(AddrGain0, patGain[idx][0]);
        wbWrite(AddrGain1, patGain[idx][1]);
        wbWrite(AddrGain2, patGain[idx][2]);
        wbWrite(AddrGain3, patGain[idx][3]);

        @(posedge clk);
        #2;
        for (int i = 0; i < NumAdc; i++) begin
            adcSamples.ch[i] = AdcWidth'(patAdc[idx][i]);
        end
        useSample  = (patUse[idx] != 0);
        syncMarker = 1'b1;
        @(posedge clk);
        #2;
        syncMarker = 1'b0;

        // Let the checker restart its record count
        repeat (6) @(posedge clk);
        waitRecords(1);
        wbWrite(AddrCsr, csrWrite);
        waitRecords(2);

        wbRead(AddrCsr, rdat);
        i_checker.checkValue({"test ", name, " overflow"}, 32'(ovf),
                             32'(rdat[CsrOverflowBit]));
        if (ovf) begin
            wbWrite(AddrCsr, csrWrite);
            wbRead(AddrCsr, rdat);
            i_checker.checkValue({"test ", name, " overflow clear"}, 0,
                                 32'(rdat[CsrOverflowBit]));
        end
        i_checker.finishTest(name);
    endtask

    task automatic readbackTest();
        logic [WbDataWidth-1:0] rdat;
        wbWrite(AddrCsr, (9 << CsrShiftLsb) | 1);
        wbWrite(AddrGain0, 12345);
        wbWrite(AddrGain1, 65536);
        wbWrite(AddrGain2, 200000);
        wbWrite(AddrGain3, 7);
        wbRead(AddrCsr, rdat);
        i_checker.checkValue("readback csr", 9 << CsrShiftLsb, rdat);
        wbRead(AddrGain0, rdat);
        i_checker.checkValue("readback gain0", 12345, rdat);
        wbRead(AddrGain1, rdat);
        i_checker.checkValue("readback gain1", 65536, rdat);
        wbRead(AddrGain2, rdat);
        i_checker.checkValue("readback gain2", 200000, rdat);
        wbRead(AddrGain3, rdat);
        i_checker.checkValue("readback gain3", 7, rdat);
        for (int a = 5; a < 8; a++) begin
            wbRead(WbAddrWidth'(a), rdat);
            i_checker.checkValue($sformatf("readback unmapped %0d", a), 0, rdat);
        end
        i_checker.finishTest("register readback");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence

    initial begin
        arstN      = 1'b0;
        wbReq      = '0;
        syncMarker = 1'b0;
        adcSamples = '0;
        useSample  = 1'b0;
        expMags    = '0;
        testNum    = 0;

        loadPatterns();
        watchdogCycles = (numTests + 1) * 3 * SamplesPerTurn + 50;

        repeat (4) @(posedge clk);
        #2;
        arstN = 1'b1;

        for (int t = 0; t < numTests; t++) begin
            runTest(t);
        end
        readbackTest();

        $display("Tests: %0d passed, %0d failed, %0d errors",
                 i_checker.testsPassed, i_checker.testsFailed, i_checker.errorCount);
        if (numTests > 0 && i_checker.errorCount == 0 && i_checker.testsFailed == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: rmsPatterns.txt
# test shift gain0 gain1 gain2 gain3 adc0 adc1 adc2 adc3 use exp0 exp1 exp2 exp3
# Gains are 2.16 unsigned, ADC values signed decimal, expected values are TBT magnitudes
1 0 65536 65536 65536 65536 100 -200 300 -50 1 770000 3080000 6930000 192500
2 3 65536 65536 65536 65536 1000 -1000 500 7 1 9625000 9625000 2406250 471
3 0 65536 32768 16384 98304 400 400 400 400 1 12320000 6160000 3080000 18480000
4 0 65536 65536 65536 65536 1234 -1234 5 6 0 0 0 0 0
5 0 65536 65536 65536 65536 -32768 -32768 32767 -32768 1 67108863 67108863 67108863 67108863
6 5 65536 131072 45000 65536 2000 -3000 150 -32768 1 9625000 43312500 37174 67108863
7 15 65536 65536 0 262143 -32768 16384 8000 -32768 1 2523136 630784 0 10092505
8 0 262143 65536 65536 65536 900 900 900 900 1 67108863 62370000 62370000 62370000

// File: files.f
rmsPkg.sv
rmsControl.sv
sampleSquarer.sv
turnAccumulator.sv
gainTrim.sv
rmsProcessing.sv
rmsChecker.sv
tbRmsProcessing.sv

// File: Makefile
VERILATOR ?= verilator
TOP       := tbRmsProcessing
FILELIST  := files.f
FLAGS     := --binary --timing --assert -Wno-fatal
OBJDIR    := obj_dir
PASSMSG   := ALL CHECKS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASSMSG)"

clean:
	rm -rf $(OBJDIR)
